//--- common/sound_pkg.sv
/*
 * shared types and encodings for the sound card slice
 * port numbers are offsets inside the 16-byte sb_cs window
 * mixer and dsp values follow the SB Pro / SB16 register map
 */
package sound_pkg;

	typedef logic signed [15:0] sample_t; // signed pcm sample
	typedef logic [4:0] vol_t;            // 0 mute, 31 full scale

	// io port offsets
	localparam logic [3:0] port_mix_idx    = 4'h4;
	localparam logic [3:0] port_mix_data   = 4'h5;
	localparam logic [3:0] port_dsp_reset  = 4'h6;
	localparam logic [3:0] port_dsp_read   = 4'hA;
	localparam logic [3:0] port_dsp_write  = 4'hC;
	localparam logic [3:0] port_dsp_status = 4'hE;

	// mixer register indices
	localparam logic [7:0] mix_reset    = 8'h00;
	localparam logic [7:0] mix_voice    = 8'h04; // pro style pair
	localparam logic [7:0] mix_stereo   = 8'h0E;
	localparam logic [7:0] mix_master   = 8'h22; // pro style pair
	localparam logic [7:0] mix_fm       = 8'h26; // pro style pair
	localparam logic [7:0] mix_master_l = 8'h30;
	localparam logic [7:0] mix_master_r = 8'h31;
	localparam logic [7:0] mix_voice_l  = 8'h32;
	localparam logic [7:0] mix_voice_r  = 8'h33;
	localparam logic [7:0] mix_fm_l     = 8'h34;
	localparam logic [7:0] mix_fm_r     = 8'h35;
	localparam logic [7:0] mix_irq_sel  = 8'h80;
	localparam logic [7:0] mix_irq_stat = 8'h82;

	// dsp commands and replies
	localparam logic [7:0] dsp_cmd_dac     = 8'h10; // direct dac, one byte follows
	localparam logic [7:0] dsp_cmd_spk_on  = 8'hD1;
	localparam logic [7:0] dsp_cmd_spk_off = 8'hD3;
	localparam logic [7:0] dsp_cmd_irq     = 8'hF2; // force 8-bit irq
	localparam logic [7:0] dsp_ready_byte  = 8'hAA;

	// one mixer data byte, read as two nibbles or as one 5-bit volume
	typedef union packed {
		struct packed {
			logic [3:0] left;
			logic [3:0] right;
		} pro;
		struct packed {
			vol_t       vol;
			logic [2:0] pad; // ignored by the card
		} sb16;
	} mixer_data_u;

endpackage

//--- hdl/sound_io.sv
/*
 * io window decode, read and write are single-cycle strobes, no wait states
 * readdata is registered and valid the cycle after the read strobe,
 * it holds until the next read; unmapped ports return 0xFF
 */
`timescale 1ns/10ps

module sound_io import sound_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] address,
	input  logic       read,
	input  logic       write,
	input  logic [7:0] writedata,
	input  logic       sb_cs,
	input  logic [7:0] mix_val,
	input  logic [7:0] dsp_val,
	output logic [7:0] readdata,
	output logic [7:0] wdata,
	output logic       mix_idx_wr,
	output logic       mix_data_wr,
	output logic       mix_data_rd,
	output logic       dsp_reset_wr,
	output logic       dsp_cmd_wr,
	output logic       dsp_read_rd,
	output logic       dsp_status_rd
);

	logic rd; // strobes qualified by chip select
	logic wr;
	logic dsp_rd;

	assign rd = read && sb_cs;
	assign wr = write && sb_cs;
	assign wdata = writedata;

	// write side
	assign mix_idx_wr   = wr && (address == port_mix_idx);
	assign mix_data_wr  = wr && (address == port_mix_data);
	assign dsp_reset_wr = wr && (address == port_dsp_reset);
	assign dsp_cmd_wr   = wr && (address == port_dsp_write);

	// read side
	assign mix_data_rd   = rd && (address == port_mix_data);
	assign dsp_read_rd   = rd && (address == port_dsp_read);
	assign dsp_status_rd = rd && (address == port_dsp_status);
	assign dsp_rd        = dsp_read_rd || dsp_status_rd;

	// capture the addressed source on the strobe, hold until next read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			readdata <= 8'h00;
		end else if (rd) begin
			if (mix_data_rd)
				readdata <= mix_val;
			else if (dsp_rd)
				readdata <= dsp_val; // dsp picks latch or status itself
			else
				readdata <= 8'hFF; // nothing mapped here
		end
	end

	// host bus never reads and writes in the same cycle
	rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write))
		else $error("read and write strobes overlap");

endmodule

//--- hdl/dsp_dac.sv
/*
 * simplified dsp with reset handshake, direct dac (0x10), speaker and forced irq
 * unsigned dac byte becomes the upper byte of a signed mono sample
 * commands written while the dsp is held in reset are dropped
 */
`timescale 1ns/10ps

module dsp_dac import sound_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       dsp_reset_wr,
	input  logic       dsp_cmd_wr,
	input  logic       dsp_read_rd,
	input  logic       dsp_status_rd,
	input  logic [7:0] wdata,
	output logic [7:0] dsp_val,
	output sample_t    dsp_sample,
	output logic       irq8
);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_reset = 2'd1; // reset bit written high
	localparam logic [1:0] st_dac   = 2'd2; // next write is a sample

	logic [1:0] state;
	logic [7:0] read_latch;
	logic       data_avail;
	logic       speaker;
	logic [7:0] dac_byte;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= st_idle;
			read_latch <= 8'h00;
			data_avail <= 1'b0;
			speaker    <= 1'b0;
			dac_byte   <= 8'h80; // silent midscale
			irq8       <= 1'b0;
		end else begin
			if (dsp_reset_wr) begin
				if (wdata[0]) begin
					state      <= st_reset;
					speaker    <= 1'b0;
					dac_byte   <= 8'h80;
					irq8       <= 1'b0;
					data_avail <= 1'b0;
				end else if (state == st_reset) begin
					// reset bit falls and the dsp reports ready
					state      <= st_idle;
					read_latch <= dsp_ready_byte;
					data_avail <= 1'b1;
				end
			end else if (dsp_cmd_wr) begin
				case (state)
					st_dac: begin
						dac_byte <= wdata;
						state    <= st_idle;
					end
					st_idle: begin
						case (wdata)
							dsp_cmd_dac:     state   <= st_dac;
							dsp_cmd_spk_on:  speaker <= 1'b1;
							dsp_cmd_spk_off: speaker <= 1'b0;
							dsp_cmd_irq:     irq8    <= 1'b1;
							default:         ; // unknown command
						endcase
					end
					default: ; // held in reset
				endcase
			end
			if (dsp_read_rd)
				data_avail <= 1'b0;
			if (dsp_status_rd)
				irq8 <= 1'b0; // status read acks the 8-bit irq
		end
	end

	assign dsp_val = dsp_status_rd ? {data_avail, 7'h00} : read_latch;
	assign dsp_sample = speaker ? {~dac_byte[7], dac_byte[6:0], 8'h00} : '0;

	// sound_io decodes a single port per bus cycle
	strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({dsp_reset_wr, dsp_cmd_wr, dsp_read_rd, dsp_status_rd}))
		else $error("more than one dsp strobe active");

endmodule

//--- mixer/mixer_regs.sv
/*
 * mixer index/data register file holding SB Pro nibble pairs and SB16 5-bit volumes
 * SB16 registers 0x30..0x35 ignore writes while SB Pro mode is on
 * index 0x00 restores every register to its reset value
 * irq select defaults to line 5 and index 0x80 moves it to 7 or 10
 */
`timescale 1ns/10ps

module mixer_regs import sound_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       mix_idx_wr,
	input  logic       mix_data_wr,
	input  logic [7:0] wdata,
	input  logic       irq8,
	output logic [7:0] mix_val,
	output vol_t       vol_l,
	output vol_t       vol_r,
	output vol_t       vol_voice_l,
	output vol_t       vol_voice_r,
	output vol_t       vol_fm_l,
	output vol_t       vol_fm_r,
	output logic       irq_5,
	output logic       irq_7,
	output logic       irq_10
);

	localparam logic [7:0] sbp_enter = 8'hAD; // magic bytes at 0x80
	localparam logic [7:0] sbp_leave = 8'hAE;
	localparam vol_t vol_full = 5'd31;

	logic [7:0]  mix_idx;
	mixer_data_u wd;
	logic        restore;
	logic        sbp; // SB Pro register mode
	logic        stereo;
	logic        irq_7_en;
	logic        irq_10_en;
	logic        irq_5_en;
	logic [7:0]  vol_mask;

	// nibble widened to 5 bits by repeating its top bit
	function automatic vol_t widen(input logic [3:0] nib);
		return {nib, nib[3]};
	endfunction

	assign wd = wdata;
	assign restore = !rst_n || (mix_data_wr && (mix_idx == mix_reset));

	always_ff @(posedge clk) begin
		if (!rst_n)
			mix_idx <= 8'h00;
		else if (mix_idx_wr)
			mix_idx <= wdata;
	end

	always_ff @(posedge clk) begin
		if (restore) begin
			vol_l       <= vol_full;
			vol_r       <= vol_full;
			vol_voice_l <= vol_full;
			vol_voice_r <= vol_full;
			vol_fm_l    <= vol_full;
			vol_fm_r    <= vol_full;
			sbp         <= 1'b0;
			stereo      <= 1'b0;
			irq_7_en    <= 1'b0;
			irq_10_en   <= 1'b0;
		end else if (mix_data_wr) begin
			case (mix_idx)
				mix_voice: begin
					vol_voice_l <= widen(wd.pro.left);
					vol_voice_r <= widen(wd.pro.right);
				end
				mix_master: begin
					vol_l <= widen(wd.pro.left);
					vol_r <= widen(wd.pro.right);
				end
				mix_fm: begin
					vol_fm_l <= widen(wd.pro.left);
					vol_fm_r <= widen(wd.pro.right);
				end
				mix_stereo: stereo <= wdata[1];
				mix_master_l: if (!sbp) vol_l <= wd.sb16.vol;
				mix_master_r: if (!sbp) vol_r <= wd.sb16.vol;
				mix_voice_l:  if (!sbp) vol_voice_l <= wd.sb16.vol;
				mix_voice_r:  if (!sbp) vol_voice_r <= wd.sb16.vol;
				mix_fm_l:     if (!sbp) vol_fm_l <= wd.sb16.vol;
				mix_fm_r:     if (!sbp) vol_fm_r <= wd.sb16.vol;
				mix_irq_sel: begin
					if (wdata == sbp_enter) begin
						sbp <= 1'b1;
					end else if (wdata == sbp_leave) begin
						sbp <= 1'b0;
					end else begin
						irq_7_en  <= (wdata[3:2] == 2'b01);
						irq_10_en <= (wdata[3:2] == 2'b10);
					end
				end
				default: ; // read-only or unmapped index
			endcase
		end
	end

	assign irq_5_en = !irq_7_en && !irq_10_en;
	assign vol_mask = sbp ? 8'hEE : 8'hFF; // pro mode drops the low nibble bit

	// readback of the currently indexed register
	always_comb begin
		case (mix_idx)
			mix_voice:    mix_val = {vol_voice_l[4:1], vol_voice_r[4:1]} & vol_mask;
			mix_master:   mix_val = {vol_l[4:1], vol_r[4:1]} & vol_mask;
			mix_fm:       mix_val = {vol_fm_l[4:1], vol_fm_r[4:1]} & vol_mask;
			mix_stereo:   mix_val = {6'd0, stereo, 1'b0};
			mix_master_l: mix_val = {vol_l, 3'b000};
			mix_master_r: mix_val = {vol_r, 3'b000};
			mix_voice_l:  mix_val = {vol_voice_l, 3'b000};
			mix_voice_r:  mix_val = {vol_voice_r, 3'b000};
			mix_fm_l:     mix_val = {vol_fm_l, 3'b000};
			mix_fm_r:     mix_val = {vol_fm_r, 3'b000};
			mix_irq_sel:  mix_val = {4'h0, irq_10_en, irq_7_en, irq_5_en, 1'b0};
			mix_irq_stat: mix_val = {7'd0, irq8};
			default:      mix_val = 8'h00;
		endcase
	end

	// dsp irq routed to the selected line only
	assign irq_5  = irq8 && irq_5_en;
	assign irq_7  = irq8 && irq_7_en;
	assign irq_10 = irq8 && irq_10_en;

	// a data write goes to the index latched before it
	idx_data_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(mix_idx_wr && mix_data_wr))
		else $error("mixer index and data written in the same cycle");

endmodule

//--- mixer/output_mix.sv
/*
 * two-stage output pipeline, sample_l/r lag their inputs by two cycles
 * volume steps are 6 dB, taken from the top four volume bits
 * each source is halved before the sum so the result cannot overflow
 */
`timescale 1ns/10ps

module output_mix import sound_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  sample_t dsp_sample,
	input  sample_t fm_l,
	input  sample_t fm_r,
	input  vol_t    vol_voice_l,
	input  vol_t    vol_voice_r,
	input  vol_t    vol_fm_l,
	input  vol_t    vol_fm_r,
	output sample_t sample_l,
	output sample_t sample_r
);

	sample_t dsp_att_l; // stage 1 results
	sample_t dsp_att_r;
	sample_t fm_att_l;
	sample_t fm_att_r;

	// vol 0 mutes, vol 31 passes unchanged
	function automatic sample_t attenuate(input sample_t smp, input vol_t vol);
		sample_t res;
		if (vol == 5'd0)
			res = '0;
		else
			res = smp >>> (4'd15 - vol[4:1]);
		return res;
	endfunction

	// stage 1, per-source volume
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dsp_att_l <= '0;
			dsp_att_r <= '0;
			fm_att_l  <= '0;
			fm_att_r  <= '0;
		end else begin
			dsp_att_l <= attenuate(dsp_sample, vol_voice_l); // mono dac on both sides
			dsp_att_r <= attenuate(dsp_sample, vol_voice_r);
			fm_att_l  <= attenuate(fm_l, vol_fm_l);
			fm_att_r  <= attenuate(fm_r, vol_fm_r);
		end
	end

	// stage 2, halve and sum
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample_l <= '0;
			sample_r <= '0;
		end else begin
			sample_l <= (dsp_att_l >>> 1) + (fm_att_l >>> 1);
			sample_r <= (dsp_att_r >>> 1) + (fm_att_r >>> 1);
		end
	end

endmodule

//--- hdl/sound.sv
/*
 * sound card slice, host side is a 4-bit io window qualified by sb_cs
 * fm samples come in on fm_l/fm_r, no opl core inside
 * no dma, irq 5/7/10 are level outputs
 */
`timescale 1ns/10ps

module sound import sound_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] address,
	input  logic       read,
	input  logic       write,
	input  logic [7:0] writedata,
	input  logic       sb_cs,
	input  sample_t    fm_l,
	input  sample_t    fm_r,
	output logic [7:0] readdata,
	output logic       irq_5,
	output logic       irq_7,
	output logic       irq_10,
	output vol_t       vol_l,
	output vol_t       vol_r,
	output sample_t    sample_l,
	output sample_t    sample_r
);

	logic [7:0] wdata;
	logic       mix_idx_wr;
	logic       mix_data_wr;
	logic       dsp_reset_wr;
	logic       dsp_cmd_wr;
	logic       dsp_read_rd;
	logic       dsp_status_rd;
	logic [7:0] mix_val;
	logic [7:0] dsp_val;
	sample_t    dsp_sample; // mono dac, feeds both channels
	logic       irq8;
	vol_t       vol_voice_l;
	vol_t       vol_voice_r;
	vol_t       vol_fm_l;
	vol_t       vol_fm_r;

	sound_io u_io (
		.clk           (clk),
		.rst_n         (rst_n),
		.address       (address),
		.read          (read),
		.write         (write),
		.writedata     (writedata),
		.sb_cs         (sb_cs),
		.mix_val       (mix_val),
		.dsp_val       (dsp_val),
		.readdata      (readdata),
		.wdata         (wdata),
		.mix_idx_wr    (mix_idx_wr),
		.mix_data_wr   (mix_data_wr),
		.mix_data_rd   (), // mixer readback is combinational, only the read mux needs it
		.dsp_reset_wr  (dsp_reset_wr),
		.dsp_cmd_wr    (dsp_cmd_wr),
		.dsp_read_rd   (dsp_read_rd),
		.dsp_status_rd (dsp_status_rd)
	);

	dsp_dac u_dsp (
		.clk           (clk),
		.rst_n         (rst_n),
		.dsp_reset_wr  (dsp_reset_wr),
		.dsp_cmd_wr    (dsp_cmd_wr),
		.dsp_read_rd   (dsp_read_rd),
		.dsp_status_rd (dsp_status_rd),
		.wdata         (wdata),
		.dsp_val       (dsp_val),
		.dsp_sample    (dsp_sample),
		.irq8          (irq8)
	);

	mixer_regs u_mix_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.mix_idx_wr  (mix_idx_wr),
		.mix_data_wr (mix_data_wr),
		.wdata       (wdata),
		.irq8        (irq8),
		.mix_val     (mix_val),
		.vol_l       (vol_l),
		.vol_r       (vol_r),
		.vol_voice_l (vol_voice_l),
		.vol_voice_r (vol_voice_r),
		.vol_fm_l    (vol_fm_l),
		.vol_fm_r    (vol_fm_r),
		.irq_5       (irq_5),
		.irq_7       (irq_7),
		.irq_10      (irq_10)
	);

	output_mix u_out (
		.clk         (clk),
		.rst_n       (rst_n),
		.dsp_sample  (dsp_sample),
		.fm_l        (fm_l),
		.fm_r        (fm_r),
		.vol_voice_l (vol_voice_l),
		.vol_voice_r (vol_voice_r),
		.vol_fm_l    (vol_fm_l),
		.vol_fm_r    (vol_fm_r),
		.sample_l    (sample_l),
		.sample_r    (sample_r)
	);

endmodule

//--- verification/sound_tb.sv
/*
 * trace driven testbench for the sound card slice
 * trace entries come from verification/sound_trace.txt, one 40-bit word each
 * stops at the first wrong value, an entry with opcode 0F ends the run
 */
`timescale 1ns/10ps

module sound_tb;

	localparam int trace_depth   = 64;
	localparam int reset_cycles  = 10;
	localparam int settle_cycles = 3; // output pipeline plus the dsp register

	logic               clk;
	logic               rst_n;
	logic [3:0]         address;
	logic               read;
	logic               write;
	logic [7:0]         writedata;
	logic               sb_cs;
	logic signed [15:0] fm_l;
	logic signed [15:0] fm_r;
	logic [7:0]         readdata;
	logic               irq_5;
	logic               irq_7;
	logic               irq_10;
	logic [4:0]         vol_l;
	logic [4:0]         vol_r;
	logic signed [15:0] sample_l;
	logic signed [15:0] sample_r;

	logic [39:0] trace [0:trace_depth-1]; // op, arg a, arg b

	sound u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.address   (address),
		.read      (read),
		.write     (write),
		.writedata (writedata),
		.sb_cs     (sb_cs),
		.fm_l      (fm_l),
		.fm_r      (fm_r),
		.readdata  (readdata),
		.irq_5     (irq_5),
		.irq_7     (irq_7),
		.irq_10    (irq_10),
		.vol_l     (vol_l),
		.vol_r     (vol_r),
		.sample_l  (sample_l),
		.sample_r  (sample_r)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic wait_clocks(input int n);
		int i;
		for (i = 0; i < n; i++)
			@(posedge clk);
	endtask

	// one-cycle write strobe
	task automatic bus_write(input logic [3:0] port, input logic [7:0] data);
		@(posedge clk);
		address   <= port;
		writedata <= data;
		write     <= 1'b1;
		sb_cs     <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		sb_cs <= 1'b0;
	endtask

	// readdata is registered, so look at it the cycle after the strobe
	task automatic bus_read(input logic [3:0] port, input logic [7:0] expected);
		@(posedge clk);
		address <= port;
		read    <= 1'b1;
		sb_cs   <= 1'b1;
		@(posedge clk);
		read  <= 1'b0;
		sb_cs <= 1'b0;
		@(negedge clk);
		assert (readdata == expected)
			else abort_run($sformatf("Mismatch at %0t: port %h read %h, expected %h",
				$time, port, readdata, expected));
	endtask

	task automatic set_fm(input logic [15:0] left, input logic [15:0] right);
		@(posedge clk);
		fm_l <= left;
		fm_r <= right;
	endtask

	task automatic compare_samples(input logic [15:0] left, input logic [15:0] right);
		wait_clocks(settle_cycles);
		@(negedge clk);
		assert (sample_l == left && sample_r == right)
			else abort_run($sformatf("Mismatch at %0t: samples %h/%h, expected %h/%h",
				$time, sample_l, sample_r, left, right));
	endtask

	task automatic expect_irqs(input logic [2:0] lines); // {irq_10, irq_7, irq_5}
		@(negedge clk);
		assert ({irq_10, irq_7, irq_5} == lines)
			else abort_run($sformatf("Mismatch at %0t: irq 10/7/5 = %b, expected %b",
				$time, {irq_10, irq_7, irq_5}, lines));
	endtask

	task automatic verify_master_vol(input logic [4:0] left, input logic [4:0] right);
		@(negedge clk);
		assert (vol_l == left && vol_r == right)
			else abort_run($sformatf("Mismatch at %0t: master volume %0d/%0d, expected %0d/%0d",
				$time, vol_l, vol_r, left, right));
	endtask

	initial begin : run_trace
		int          idx;
		logic [7:0]  op;
		logic [15:0] arg_a;
		logic [15:0] arg_b;
		logic        done;

		rst_n     = 1'b0;
		address   = 4'h0;
		read      = 1'b0;
		write     = 1'b0;
		writedata = 8'h00;
		sb_cs     = 1'b0;
		fm_l      = '0;
		fm_r      = '0;
		done      = 1'b0;
		$readmemh("verification/sound_trace.txt", trace);
		if ($isunknown(trace[0]))
			abort_run("trace file is missing or its first entry is unreadable");
		wait_clocks(reset_cycles);
		rst_n <= 1'b1;

		for (idx = 0; idx < trace_depth && !done; idx++) begin
			op    = trace[idx][39:32];
			arg_a = trace[idx][31:16];
			arg_b = trace[idx][15:0];
			case (op)
				8'h01: bus_write(arg_a[3:0], arg_b[7:0]);
				8'h02: bus_read(arg_a[3:0], arg_b[7:0]);
				8'h03: set_fm(arg_a, arg_b);
				8'h04: compare_samples(arg_a, arg_b);
				8'h05: expect_irqs(arg_b[2:0]);
				8'h06: verify_master_vol(arg_a[4:0], arg_b[4:0]);
				8'h0F: done = 1'b1; // end marker
				default: abort_run($sformatf("unknown trace opcode %h in entry %0d", op, idx));
			endcase
		end

		if (done) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("trace ran out of entries without an end marker");
		end
	end

endmodule

//--- verification/sound_trace.txt
// op_aaaa_bbbb, op 01 write port a data b, 02 read port a expect b, 03 fm_l a fm_r b
// op 04 expect sample_l a sample_r b, 05 expect irq {10,7,5} in b, 06 master vol a/b, 0F end
01_0004_0022 // reset defaults, master pair
02_0005_00FF
06_001F_001F
05_0000_0000
01_0004_0080
02_0005_0002 // irq 5 selected
01_0004_0026 // fm pair 0x93 gives 19 and 6
01_0005_0093
02_0005_0093
01_0004_0034
02_0005_0098
01_0004_0032 // voice left 8
01_0005_0040
02_0005_0040
01_0004_0080 // enter sb pro mode
01_0005_00AD
01_0004_0026
02_0005_0082
01_0004_0033 // sb16 write ignored in pro mode
01_0005_0000
02_0005_00F8
01_0004_0080 // back to sb16 mode
01_0005_00AE
01_0006_0001 // dsp reset handshake
01_0006_0000
02_000E_0080
02_000A_00AA
02_000E_0000
03_F000_2000 // fm input
01_000C_00D1 // speaker on, direct dac 0xC0
01_000C_0010
01_000C_00C0
04_FFE4_2001
01_000C_00D3 // speaker off
04_FFE0_0001
01_000C_00F2 // forced irq on line 5
05_0000_0001
01_0004_0082
02_0005_0001
02_000E_0000
05_0000_0000
01_0004_0080 // route to irq 10
01_0005_0008
01_000C_00F2
05_0000_0004
02_000E_0000
05_0000_0000
0F_0000_0000

//--- sound.f
common/sound_pkg.sv
hdl/sound_io.sv
hdl/dsp_dac.sv
mixer/mixer_regs.sv
mixer/output_mix.sv
hdl/sound.sv
verification/sound_tb.sv
